// ==== Bender.yml ====
package:
  name: odt_ctrl

export_include_dirs:
  - hw

sources:
  # RTL, package first
  - include_dirs:
      - hw
    files:
      - hw/odt_pkg.sv
      - hw/odt_rank_map.sv
      - hw/odt_window_gen.sv
      - hw/odt_ctrl_top.sv

  # directed testbench, top module odt_tb
  - target: test
    include_dirs:
      - hw
    files:
      - bench/odt_tb.sv

// ==== bench/odt_tb.sv ====
// directed ODT testbench; latencies change only after the windows drain, and chips are picked per the 4-rank group
`timescale 1ns/10ps
`include "odt_macros.svh"

module odt_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int DRAIN       = `ODT_LAT_MAX + `ODT_PULSE_CYCLES + 2;
    localparam int ROUNDS      = 6;
    localparam int RANDOM_LEN  = 40;
    localparam int OVERLAP_LEN = 20;
    // reset, idle, per-chip writes and reads, broadcast, overlap, random rounds
    localparam int RUN_CYCLES  = 5 + 20 + 2 * `ODT_NUM_RANKS * (1 + DRAIN) + (1 + DRAIN)
                                 + 2 * (OVERLAP_LEN + DRAIN) + ROUNDS * (RANDOM_LEN + DRAIN);
    localparam int MARGIN      = 100;

    logic                ctl_clk;
    logic                ctl_reset_n;
    odt_pkg::lat_t       mem_tcl;
    odt_pkg::lat_t       mem_cas_wr_lat;
    logic                do_write;
    logic                do_read;
    odt_pkg::rank_mask_t to_chip;
    odt_pkg::rank_mask_t afi_odt;

    int                  edge_cnt;
    int                  error_cnt;
    int                  timeout_cnt;
    logic [31:0]         rng;
    int                  win_start[$];   // first edge after which the window is high
    odt_pkg::rank_mask_t win_mask[$];

    odt_ctrl_top DUT
    (
        .ctl_clk        (ctl_clk),
        .ctl_reset_n    (ctl_reset_n),
        .mem_tcl        (mem_tcl),
        .mem_cas_wr_lat (mem_cas_wr_lat),
        .do_write       (do_write),
        .do_read        (do_read),
        .to_chip        (to_chip),
        .afi_odt        (afi_odt)
    );

    initial
    begin
        ctl_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    always @(posedge ctl_clk)
        edge_cnt <= edge_cnt + 1;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // rank at the same position on the other DIMM of the group terminates too
    function automatic odt_pkg::rank_mask_t expected_ranks(input odt_pkg::cmd_e kind,
                                                           input odt_pkg::rank_mask_t chip);
        odt_pkg::rank_mask_t ranks;
        int                  other;
        ranks = '0;
        if (kind == odt_pkg::cmd_write && (&chip))
            return '1;                                      // broadcast write
        for (int r = 0; r < `ODT_NUM_RANKS; r++)
        begin
            if (chip[r])
            begin
                other = (r - r % `ODT_GROUP) + ((r % `ODT_GROUP) ^ 2);
                ranks[other] = 1'b1;
                if (kind == odt_pkg::cmd_write)
                    ranks[r] = 1'b1;
            end
        end
        return ranks;
    endfunction

    function automatic odt_pkg::rank_mask_t predict(input int n);
        odt_pkg::rank_mask_t m;
        m = '0;
        foreach (win_start[i])
            if (n >= win_start[i] && n < win_start[i] + `ODT_PULSE_CYCLES)
                m = m | win_mask[i];
        return m;
    endfunction

    ////////////////////////////////////////
    // checks and drivers
    ////////////////////////////////////////

    task automatic check_mask(input string name, input odt_pkg::rank_mask_t expected,
                              input odt_pkg::rank_mask_t actual);
        if (actual !== expected)
        begin
            error_cnt++;
            $display("error %s expected %b actual %b (edge %0d)", name, expected, actual,
                     edge_cnt);
        end
    endtask

    task automatic check_lat(input string name, input odt_pkg::lat_t expected,
                             input odt_pkg::lat_t actual);
        if (actual !== expected || actual < `ODT_LAT_MIN || actual > `ODT_LAT_MAX)
        begin
            error_cnt++;
            $display("error %s expected %0d (%0d..%0d) actual %0d", name, expected,
                     `ODT_LAT_MIN, `ODT_LAT_MAX, actual);
        end
    endtask

    // check the output after the last edge, then drive the next command
    task automatic tick(input string name, input odt_pkg::cmd_e kind,
                        input odt_pkg::rank_mask_t chip);
        odt_pkg::lat_t lat;
        @(negedge ctl_clk);
        check_mask(name, predict(edge_cnt), afi_odt);
        do_write = (kind == odt_pkg::cmd_write);
        do_read  = (kind == odt_pkg::cmd_read);
        to_chip  = chip;
        if (kind != odt_pkg::cmd_idle)
        begin
            lat = (kind == odt_pkg::cmd_write) ? mem_cas_wr_lat : mem_tcl;
            win_start.push_back(edge_cnt + lat);            // E0 = edge_cnt + 1, opens at E0+L-1
            win_mask.push_back(expected_ranks(kind, chip));
        end
    endtask

    task automatic drain(input string name);
        repeat (DRAIN) tick(name, odt_pkg::cmd_idle, '0);
        win_start.delete();
        win_mask.delete();
    endtask

    // latencies as seen by the first and the last window generator
    task automatic set_latencies(input string name, input odt_pkg::lat_t tcl,
                                 input odt_pkg::lat_t cwl);
        mem_tcl        = tcl;
        mem_cas_wr_lat = cwl;
        #1;
        check_lat(name, tcl, DUT.g_rank[0].u_window_gen.mem_tcl);
        check_lat(name, cwl, DUT.g_rank[0].u_window_gen.mem_cas_wr_lat);
        check_lat(name, tcl, DUT.g_rank[`ODT_NUM_RANKS-1].u_window_gen.mem_tcl);
        check_lat(name, cwl, DUT.g_rank[`ODT_NUM_RANKS-1].u_window_gen.mem_cas_wr_lat);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic idle_after_reset();
        repeat (20) tick("idle_after_reset", odt_pkg::cmd_idle, '0);
    endtask

    task automatic single_commands(input string name, input odt_pkg::cmd_e kind);
        for (int r = 0; r < `ODT_NUM_RANKS; r++)
        begin
            tick(name, kind, odt_pkg::rank_mask_t'(1) << r);
            drain(name);
        end
    endtask

    task automatic broadcast_write();
        tick("broadcast_write", odt_pkg::cmd_write, '1);
        drain("broadcast_write");
    endtask

    task automatic overlapping_commands(input odt_pkg::lat_t tcl, input odt_pkg::lat_t cwl);
        set_latencies("overlap", tcl, cwl);
        tick("overlap", odt_pkg::cmd_write, 4'b0001);
        tick("overlap", odt_pkg::cmd_read,  4'b0010);
        tick("overlap", odt_pkg::cmd_idle,  '0);
        tick("overlap", odt_pkg::cmd_write, 4'b0100);       // same pair as the first write
        tick("overlap", odt_pkg::cmd_read,  4'b1000);
        tick("overlap", odt_pkg::cmd_write, 4'b0001);
        tick("overlap", odt_pkg::cmd_write, 4'b0010);       // back to back
        tick("overlap", odt_pkg::cmd_write, 4'b0010);
        repeat (3) tick("overlap", odt_pkg::cmd_idle, '0);
        tick("overlap", odt_pkg::cmd_read,  4'b0001);
        tick("overlap", odt_pkg::cmd_read,  4'b0100);
        tick("overlap", odt_pkg::cmd_write, 4'b1000);
        repeat (OVERLAP_LEN - 14) tick("overlap", odt_pkg::cmd_idle, '0);
        drain("overlap");
    endtask

    task automatic random_commands();
        odt_pkg::cmd_e       kind;
        odt_pkg::rank_mask_t chip;
        odt_pkg::lat_t       tcl;
        odt_pkg::lat_t       cwl;
        for (int round = 0; round < ROUNDS; round++)
        begin
            rng = xorshift32(rng);
            tcl = `ODT_LAT_MIN + rng[7:0] % (`ODT_LAT_MAX - `ODT_LAT_MIN + 1);
            cwl = `ODT_LAT_MIN + rng[15:8] % (`ODT_LAT_MAX - `ODT_LAT_MIN + 1);
            set_latencies("random", tcl, cwl);
            repeat (RANDOM_LEN)
            begin
                rng  = xorshift32(rng);
                chip = odt_pkg::rank_mask_t'(1) << (rng[9:2] % `ODT_NUM_RANKS);
                case (rng[1:0])
                    2'd0:    kind = odt_pkg::cmd_write;
                    2'd1:    kind = odt_pkg::cmd_read;
                    default: kind = odt_pkg::cmd_idle;
                endcase
                if (kind == odt_pkg::cmd_write && rng[14:12] == 3'd0)
                    chip = '1;
                tick("random", kind, (kind == odt_pkg::cmd_idle) ? '0 : chip);
            end
            drain("random");
        end
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial
    begin
        ctl_reset_n    = 1'b0;
        do_write       = 1'b0;
        do_read        = 1'b0;
        to_chip        = '0;
        mem_tcl        = 6;
        mem_cas_wr_lat = 5;
        edge_cnt       = 0;
        error_cnt      = 0;
        timeout_cnt    = 0;
        rng            = 32'h8ab572fd;
        repeat (5) @(posedge ctl_clk);
        @(negedge ctl_clk);
        ctl_reset_n = 1'b1;

        idle_after_reset();
        single_commands("write_each_chip", odt_pkg::cmd_write);
        single_commands("read_each_chip", odt_pkg::cmd_read);
        broadcast_write();
        overlapping_commands(7, 5);
        overlapping_commands(3, 9);                         // reads land ahead of writes
        random_commands();

        $display("errors: %0d  timeouts: %0d", error_cnt, timeout_cnt);
        if (error_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
        timeout_cnt++;
        $display("watchdog: the tests did not finish within %0d cycles", RUN_CYCLES + MARGIN);
        $display("errors: %0d  timeouts: %0d", error_cnt, timeout_cnt);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== hw/odt_ctrl_top.sv ====
// DDR3 ODT generator top, full-rate output only; command strobes are accepted without back-pressure
`timescale 1ns/10ps
`include "odt_macros.svh"

module odt_ctrl_top
(
    input  logic                     ctl_clk,
    input  logic                     ctl_reset_n,
    input  odt_pkg::lat_t            mem_tcl,
    input  odt_pkg::lat_t            mem_cas_wr_lat,
    input  logic                     do_write,
    input  logic                     do_read,
    input  odt_pkg::rank_mask_t      to_chip,
    output wire odt_pkg::rank_mask_t afi_odt     // one pin per rank
);

    odt_pkg::rank_mask_t write_to_rank;
    odt_pkg::rank_mask_t read_to_rank;

    ////////////////////////////////////////
    // command to rank mapping
    ////////////////////////////////////////

    odt_rank_map u_rank_map
    (
        .ctl_clk       (ctl_clk),
        .ctl_reset_n   (ctl_reset_n),
        .do_write      (do_write),
        .do_read       (do_read),
        .to_chip       (to_chip),
        .write_to_rank (write_to_rank),
        .read_to_rank  (read_to_rank)
    );

    ////////////////////////////////////////
    // per-rank windows
    ////////////////////////////////////////

    for (genvar k = 0; k < `ODT_NUM_RANKS; k++)
    begin : g_rank
        odt_window_gen u_window_gen
        (
            .ctl_clk        (ctl_clk),
            .ctl_reset_n    (ctl_reset_n),
            .mem_tcl        (mem_tcl),
            .mem_cas_wr_lat (mem_cas_wr_lat),
            .write_start    (write_to_rank[k]),
            .read_start     (read_to_rank[k]),
            .odt            (afi_odt[k])
        );
    end

endmodule

// ==== hw/odt_macros.svh ====
// DDR3 ODT constants; rank count must be a multiple of the 4-rank group, latencies 2 to 15 only
`ifndef ODT_MACROS_SVH
`define ODT_MACROS_SVH

////////////////////////////////////////
// rank layout
////////////////////////////////////////

// chip selects and ODT pins, two dual-rank DIMMs per group
`define ODT_NUM_RANKS 4

// ranks per two-DIMM group, partner rank sits half a group away
`define ODT_GROUP 4

////////////////////////////////////////
// timing
////////////////////////////////////////

`define ODT_PULSE_CYCLES 6   // termination window length in controller cycles

// legal CAS latency and CAS write latency range
`define ODT_LAT_MIN 2
`define ODT_LAT_MAX 15

`define ODT_LAT_W 4          // latency field width, must hold ODT_LAT_MAX

`endif

// ==== hw/odt_pkg.sv ====
// shared ODT types; widths come from odt_macros.svh and no other setting changes them
`include "odt_macros.svh"

package odt_pkg;

    ////////////////////////////////////////
    // rank vectors
    ////////////////////////////////////////

    // one bit per chip select, also one bit per ODT pin
    typedef logic [`ODT_NUM_RANKS-1:0] rank_mask_t;

    ////////////////////////////////////////
    // latency
    ////////////////////////////////////////

    // unsigned latency in controller cycles, tcl or cwl
    typedef logic [`ODT_LAT_W-1:0] lat_t;

    ////////////////////////////////////////
    // command kind
    ////////////////////////////////////////

    // registered command as seen by the rank mapper
    typedef enum logic [1:0]
    {
        cmd_idle  = 2'd0,
        cmd_write = 2'd1,
        cmd_read  = 2'd2
    } cmd_e;

endpackage

// ==== hw/odt_rank_map.sv ====
// maps a registered DDR3 read or write to terminating ranks; assumes dual-rank DIMMs in groups of 4
`timescale 1ns/10ps
`include "odt_macros.svh"

module odt_rank_map
(
    input  logic                ctl_clk,
    input  logic                ctl_reset_n,
    input  logic                do_write,       // single-cycle strobe
    input  logic                do_read,        // single-cycle strobe
    input  odt_pkg::rank_mask_t to_chip,        // one-hot, or all ones for a write
    output odt_pkg::rank_mask_t write_to_rank,  // ranks to terminate for a write
    output odt_pkg::rank_mask_t read_to_rank    // ranks to terminate for a read
);

    localparam int NUM_GROUPS = `ODT_NUM_RANKS / `ODT_GROUP;
    localparam int HALF_GROUP = `ODT_GROUP / 2;

    odt_pkg::cmd_e       cmd_d;
    odt_pkg::cmd_e       cmd_q;
    odt_pkg::rank_mask_t chip_q;
    odt_pkg::rank_mask_t partner_mask;

    // same-position rank on the other DIMM of the group
    // 0 <-> 2 and 1 <-> 3 within every group of four
    function automatic odt_pkg::rank_mask_t partner_of(input odt_pkg::rank_mask_t chips);
        odt_pkg::rank_mask_t swapped;
        swapped = '0;
        for (int g = 0; g < NUM_GROUPS; g++)
        begin
            for (int j = 0; j < `ODT_GROUP; j++)
            begin
                swapped[g*`ODT_GROUP + ((j + HALF_GROUP) % `ODT_GROUP)] =
                    chips[g*`ODT_GROUP + j];
            end
        end
        return swapped;
    endfunction

    ////////////////////////////////////////
    // command register
    ////////////////////////////////////////

    always_comb
    begin
        if (do_write)
            cmd_d = odt_pkg::cmd_write;
        else if (do_read)
            cmd_d = odt_pkg::cmd_read;
        else
            cmd_d = odt_pkg::cmd_idle;
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
            cmd_q <= odt_pkg::cmd_idle;
        else
            cmd_q <= cmd_d;
    end

    // addressed chips of the last accepted command
    always_ff @(posedge ctl_clk)
    begin
        if (do_write || do_read)
            chip_q <= to_chip;
    end

    ////////////////////////////////////////
    // termination masks
    ////////////////////////////////////////

    assign partner_mask = partner_of(chip_q);

    // a write terminates the addressed rank and its partner, so all ones stays all ones
    // a read terminates only the partner because the addressed rank drives the bus
    always_comb
    begin
        write_to_rank = '0;
        read_to_rank  = '0;
        case (cmd_q)
            odt_pkg::cmd_write: write_to_rank = chip_q | partner_mask;
            odt_pkg::cmd_read:  read_to_rank  = partner_mask;
            default:            ;               // nothing terminates while idle
        endcase
    end

    ////////////////////////////////////////
    // command contract checks
    ////////////////////////////////////////

    // the controller issues at most one command per cycle
    assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        !(do_write && do_read))
    else $error("odt_rank_map: read and write strobed together");

    // a read addresses exactly one rank
    assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        do_read |-> $onehot(to_chip))
    else $error("odt_rank_map: read chip vector not one-hot");

    // a write addresses one rank or broadcasts to all of them
    assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        do_write |-> ($onehot(to_chip) || (&to_chip)))
    else $error("odt_rank_map: write chip vector neither one-hot nor all ones");

endmodule

// ==== hw/odt_window_gen.sv ====
// one ODT pin; latencies must stay within 2..15 and only change while no window is pending
`timescale 1ns/10ps
`include "odt_macros.svh"

module odt_window_gen
(
    input  logic          ctl_clk,
    input  logic          ctl_reset_n,
    input  odt_pkg::lat_t mem_tcl,          // CAS latency, places read windows
    input  odt_pkg::lat_t mem_cas_wr_lat,   // CAS write latency, places write windows
    input  logic          write_start,      // one cycle after the write is sampled
    input  logic          read_start,       // one cycle after the read is sampled
    output logic          odt
);

    localparam int CNT_W = $clog2(`ODT_PULSE_CYCLES + 1);

    logic [`ODT_LAT_MAX-1:0] wr_shift;      // write delay line
    logic [`ODT_LAT_MAX-1:0] rd_shift;      // read delay line
    logic [`ODT_LAT_MAX:0]   wr_chain;      // start plus every delayed copy
    logic [`ODT_LAT_MAX:0]   rd_chain;
    odt_pkg::lat_t           wr_tap_sel;
    odt_pkg::lat_t           rd_tap_sel;
    logic                    wr_tap;
    logic                    rd_tap;
    logic                    load;
    logic [CNT_W-1:0]        pulse_cnt;
    logic [CNT_W-1:0]        pulse_cnt_nxt;

    ////////////////////////////////////////
    // latency delay lines
    ////////////////////////////////////////

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            wr_shift <= '0;
            rd_shift <= '0;
        end
        else
        begin
            wr_shift <= {wr_shift[`ODT_LAT_MAX-2:0], write_start};
            rd_shift <= {rd_shift[`ODT_LAT_MAX-2:0], read_start};
        end
    end

    assign wr_chain = {wr_shift, write_start};
    assign rd_chain = {rd_shift, read_start};

    // L-2 stages; one cycle is spent in the mapper and one loading the counter
    assign wr_tap_sel = mem_cas_wr_lat - odt_pkg::lat_t'(2);
    assign rd_tap_sel = mem_tcl - odt_pkg::lat_t'(2);

    assign wr_tap = wr_chain[wr_tap_sel];
    assign rd_tap = rd_chain[rd_tap_sel];
    assign load   = wr_tap | rd_tap;

    ////////////////////////////////////////
    // pulse counter
    ////////////////////////////////////////

    // a new start reloads the count, so overlapping windows merge
    always_comb
    begin
        if (load)
            pulse_cnt_nxt = CNT_W'(`ODT_PULSE_CYCLES);
        else if (pulse_cnt != '0)
            pulse_cnt_nxt = pulse_cnt - 1'b1;
        else
            pulse_cnt_nxt = '0;
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            pulse_cnt <= '0;
            odt       <= 1'b0;
        end
        else
        begin
            pulse_cnt <= pulse_cnt_nxt;
            odt       <= (pulse_cnt_nxt != '0);   // flopped, drives the pin cleanly
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // out-of-range latencies would tap a wrapped index
    assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (mem_tcl >= `ODT_LAT_MIN) && (mem_tcl <= `ODT_LAT_MAX) &&
        (mem_cas_wr_lat >= `ODT_LAT_MIN) && (mem_cas_wr_lat <= `ODT_LAT_MAX))
    else $error("odt_window_gen: latency setting out of range");

    // without a fresh start the window closes after the pulse length
    assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (!load) [*`ODT_PULSE_CYCLES] |=> !odt)
    else $error("odt_window_gen: odt held past the termination window");

endmodule

// ==== sources.f ====
+incdir+hw
hw/odt_pkg.sv
hw/odt_rank_map.sv
hw/odt_window_gen.sv
hw/odt_ctrl_top.sv
bench/odt_tb.sv
